//--- Makefile
TOP       ?= tb_hps_io
FILELIST  ?= hps_io_sys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) hps_io_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hps_cmd_parser.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module hps_cmd_parser (
	input  logic        clk_100,
	input  logic        rst_n,
	input  logic        io_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	input  logic [7:0]  vid_nres,
	input  logic [31:0] vid_hcnt,
	input  logic [31:0] vid_vcnt,
	input  logic [31:0] vid_htime,
	input  logic [31:0] vid_vtime,
	output logic [15:0] io_dout,
	output logic        io_wait,
	output logic [15:0] joy0,
	output logic [15:0] joy1,
	output logic [15:0] joy2,
	output logic [15:0] joy3,
	output logic [1:0]  buttons,
	output logic [3:0]  conf,
	output logic [2:0]  mouse_buttons,
	output logic [63:0] rtc,
	output logic [11:0] shbl_l,
	output logic [11:0] shbl_r,
	output logic [11:0] svbl_t,
	output logic [11:0] svbl_b,
	output logic        sset,
	kms_event_if.producer ev
);
	localparam int WAIT_CYCLES = `HPS_WAIT_CYCLES;
	localparam int WW          = $clog2(WAIT_CYCLES + 1);

	hps_io_pkg::parse_state_e state;
	hps_io_pkg::hps_cmd_e     cmd;
	hps_io_pkg::hps_cmd_e     opcode;
	hps_io_pkg::kms_type_e    push_kind;
	hps_io_pkg::kms_type_e    ev_kind;
	logic [3:0]               widx;  // 1 = first payload word
	logic [WW-1:0]            wait_cnt;
	logic                     word_in;
	logic                     pay_word;
	logic                     ev_push;
	logic                     ev_valid;
	logic [7:0]               ev_data;

	assign opcode   = hps_io_pkg::hps_cmd_e'(io_din[7:0]);
	assign word_in  = io_ena && io_strobe;
	assign pay_word = word_in && (state == hps_io_pkg::PS_PAYLOAD);

	assign ev.valid = ev_valid;
	assign ev.kind  = ev_kind;
	assign ev.data  = ev_data;

	function automatic logic [15:0] read_word(input hps_io_pkg::hps_cmd_e op,
	                                          input logic [3:0] idx);
		logic [15:0] w;
		w = 16'h0000;
		case (op)
			hps_io_pkg::CMD_IDENT:      w = 16'h0001;
			hps_io_pkg::CMD_UART_FLAGS: w = 16'h1F1F;
			hps_io_pkg::CMD_VIDEO_INFO: begin
				case (idx)
					4'd1: w = {8'h00, vid_nres};
					4'd2: w = vid_hcnt[15:0];
					4'd3: w = vid_hcnt[31:16];
					4'd4: w = vid_vcnt[15:0];
					4'd5: w = vid_vcnt[31:16];
					4'd6: w = vid_htime[15:0];
					4'd7: w = vid_htime[31:16];
					4'd8: w = vid_vtime[15:0];
					4'd9: w = vid_vtime[31:16];
					default: w = 16'h0000;
				endcase
			end
			default: w = 16'h0000;
		endcase
		return w;
	endfunction

	// mouse gives X on word 1 and Y on word 2
	always_comb begin
		ev_push   = 1'b0;
		push_kind = hps_io_pkg::KMS_KEY;
		if (pay_word) begin
			case (cmd)
				hps_io_pkg::CMD_MOUSE: begin
					ev_push   = (widx == 4'd1) || (widx == 4'd2);
					push_kind = (widx == 4'd1) ? hps_io_pkg::KMS_MOUSE_X : hps_io_pkg::KMS_MOUSE_Y;
				end
				hps_io_pkg::CMD_KBD:     ev_push = (widx == 4'd1);
				hps_io_pkg::CMD_OSD_KBD: begin
					ev_push   = (widx == 4'd1);
					push_kind = hps_io_pkg::KMS_OSD_KEY;
				end
				default: ev_push = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_100) begin
		if (ev_push) begin
			ev_kind <= push_kind;
			ev_data <= io_din[7:0];
		end
	end

	always_ff @(posedge clk_100) begin
		if (!rst_n) begin
			state         <= hps_io_pkg::PS_IDLE;
			cmd           <= hps_io_pkg::CMD_NONE;
			widx          <= '0;
			wait_cnt      <= '0;
			io_wait       <= 1'b0;
			io_dout       <= '0;
			sset          <= 1'b0;
			ev_valid      <= 1'b0;
			joy0          <= '0;
			joy1          <= '0;
			joy2          <= '0;
			joy3          <= '0;
			buttons       <= '0;
			conf          <= '0;
			mouse_buttons <= '0;
			rtc           <= '0;
			shbl_l        <= '0;
			shbl_r        <= '0;
			svbl_t        <= '0;
			svbl_b        <= '0;
		end else begin
			sset <= 1'b0;
			if (ev_valid && ev.ready)
				ev_valid <= 1'b0;
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;
			else if (!ev_valid || ev.ready)
				io_wait <= 1'b0;  // window over, nothing pending

			if (!io_ena) begin
				if (cmd == hps_io_pkg::CMD_SCREEN_SET)
					sset <= 1'b1;
				if (!ev_valid || ev.ready)
					io_wait <= 1'b0;
				state    <= hps_io_pkg::PS_IDLE;
				cmd      <= hps_io_pkg::CMD_NONE;
				widx     <= '0;
				wait_cnt <= '0;
			end else if (word_in) begin
				wait_cnt <= WW'(WAIT_CYCLES - 1);
				io_wait  <= 1'b1;
				case (state)
					hps_io_pkg::PS_IDLE, hps_io_pkg::PS_OPCODE: begin
						cmd     <= opcode;
						widx    <= 4'd1;
						state   <= hps_io_pkg::PS_PAYLOAD;
						io_dout <= read_word(opcode, 4'd0);
					end
					hps_io_pkg::PS_PAYLOAD: begin
						io_dout <= read_word(cmd, widx);
						if (widx == 4'hF)
							state <= hps_io_pkg::PS_HOLD;
						else
							widx <= widx + 4'd1;
						case (cmd)
							hps_io_pkg::CMD_BUTTONS: if (widx == 4'd1) begin
								buttons <= io_din[1:0];
								conf    <= io_din[7:4];
							end
							hps_io_pkg::CMD_JOY0:  if (widx == 4'd1) joy0 <= io_din;
							hps_io_pkg::CMD_JOY1:  if (widx == 4'd1) joy1 <= io_din;
							hps_io_pkg::CMD_JOY2:  if (widx == 4'd1) joy2 <= io_din;
							hps_io_pkg::CMD_JOY3:  if (widx == 4'd1) joy3 <= io_din;
							hps_io_pkg::CMD_MOUSE: if (widx == 4'd3) mouse_buttons <= io_din[2:0];
							hps_io_pkg::CMD_RTC: begin
								case (widx)  // low word first
									4'd1: rtc[15:0]  <= io_din;
									4'd2: rtc[31:16] <= io_din;
									4'd3: rtc[47:32] <= io_din;
									4'd4: rtc[63:48] <= io_din;
									default: ;
								endcase
							end
							hps_io_pkg::CMD_SCREEN_SET: begin
								case (widx)
									4'd1: shbl_l <= io_din[11:0];
									4'd2: shbl_r <= io_din[11:0];
									4'd3: svbl_t <= io_din[11:0];
									4'd4: svbl_b <= io_din[11:0];
									default: ;
								endcase
							end
							default: ;
						endcase
					end
					default: io_dout <= '0;
				endcase
			end else if (state == hps_io_pkg::PS_IDLE) begin
				state <= hps_io_pkg::PS_OPCODE;
			end

			if (ev_push)
				ev_valid <= 1'b1;
		end
	end

	// host must be held off while the hold register is busy
	a_hold_no_overwrite: assert property (@(posedge clk_100) disable iff (!rst_n)
		ev_push |-> (!ev_valid || ev.ready));

	a_wait_while_pending: assert property (@(posedge clk_100) disable iff (!rst_n)
		ev_valid |-> io_wait);

endmodule

//--- hps_io_defines.svh
`ifndef HPS_IO_DEFINES_SVH
`define HPS_IO_DEFINES_SVH

// entries in the keyboard/mouse event queue
`define HPS_KMS_DEPTH 8

// io_wait length after each host word
`define HPS_WAIT_CYCLES 8

// min clocks between kbd_mouse_strobe pulses
`define HPS_KMS_GAP 4

// unchanged frames before a new resolution is reported
`define HPS_STABLE_FRAMES 15

`endif

//--- hps_io_pkg.sv
package hps_io_pkg;

	// host opcodes, first word of every command
	typedef enum logic [7:0] {
		CMD_NONE       = 8'h00,
		CMD_BUTTONS    = 8'h01,
		CMD_JOY0       = 8'h02,
		CMD_JOY1       = 8'h03,
		CMD_MOUSE      = 8'h04,
		CMD_KBD        = 8'h05,
		CMD_OSD_KBD    = 8'h06,
		CMD_JOY2       = 8'h10,
		CMD_JOY3       = 8'h11,
		CMD_RTC        = 8'h22,
		CMD_VIDEO_INFO = 8'h23,
		CMD_UART_FLAGS = 8'h28,
		CMD_IDENT      = 8'h2B,
		CMD_SCREEN_SET = 8'h2D
	} hps_cmd_e;

	typedef enum logic [1:0] {
		KMS_MOUSE_X = 2'd0,
		KMS_MOUSE_Y = 2'd1,
		KMS_KEY     = 2'd2,
		KMS_OSD_KEY = 2'd3
	} kms_type_e;

	typedef enum logic [1:0] {
		PS_IDLE,    // io_ena low
		PS_OPCODE,  // waiting for the opcode word
		PS_PAYLOAD,
		PS_HOLD     // word index saturated, rest ignored
	} parse_state_e;

endpackage

//--- hps_io_sys.f
+incdir+.
hps_io_pkg.sv
kms_event_if.sv
hps_cmd_parser.sv
kms_event_fifo.sv
kms_output.sv
video_meter.sv
hps_io_sys.sv
tb_hps_checker.sv
tb_hps_io.sv

//--- hps_io_sys.sv
`timescale 1ns/10ps

module hps_io_sys (
	input  logic        clk_100,
	input  logic        rst_n,

	input  logic        IO_ENA,
	input  logic        IO_STROBE,
	input  logic [15:0] IO_DIN,
	output logic [15:0] IO_DOUT,
	output logic        IO_WAIT,

	output logic [15:0] JOY0,
	output logic [15:0] JOY1,
	output logic [15:0] JOY2,
	output logic [15:0] JOY3,

	output logic [2:0]  MOUSE_BUTTONS,
	output logic        KBD_MOUSE_STROBE,
	output logic        KMS_LEVEL,
	output logic [1:0]  KBD_MOUSE_TYPE,
	output logic [7:0]  KBD_MOUSE_DATA,

	output logic [1:0]  BUTTONS,
	output logic [3:0]  CONF,

	input  logic        ce_pix,
	input  logic        de,
	input  logic        hs,
	input  logic        vs,
	input  logic        f1,

	output logic [11:0] shbl_l,
	output logic [11:0] shbl_r,
	output logic [11:0] svbl_t,
	output logic [11:0] svbl_b,
	output logic        sset,

	output logic [63:0] RTC
);
	logic [7:0]  vid_nres;
	logic [31:0] vid_hcnt;
	logic [31:0] vid_vcnt;
	logic [31:0] vid_htime;
	logic [31:0] vid_vtime;

	kms_event_if ev_in ();   // parser to queue
	kms_event_if ev_out ();  // queue to output

	hps_cmd_parser i_parser (
		.clk_100       (clk_100),
		.rst_n         (rst_n),
		.io_ena        (IO_ENA),
		.io_strobe     (IO_STROBE),
		.io_din        (IO_DIN),
		.vid_nres      (vid_nres),
		.vid_hcnt      (vid_hcnt),
		.vid_vcnt      (vid_vcnt),
		.vid_htime     (vid_htime),
		.vid_vtime     (vid_vtime),
		.io_dout       (IO_DOUT),
		.io_wait       (IO_WAIT),
		.joy0          (JOY0),
		.joy1          (JOY1),
		.joy2          (JOY2),
		.joy3          (JOY3),
		.buttons       (BUTTONS),
		.conf          (CONF),
		.mouse_buttons (MOUSE_BUTTONS),
		.rtc           (RTC),
		.shbl_l        (shbl_l),
		.shbl_r        (shbl_r),
		.svbl_t        (svbl_t),
		.svbl_b        (svbl_b),
		.sset          (sset),
		.ev            (ev_in)
	);

	kms_event_fifo i_fifo (
		.clk_100 (clk_100),
		.rst_n   (rst_n),
		.wr      (ev_in),
		.rd      (ev_out)
	);

	kms_output i_kms (
		.clk_100          (clk_100),
		.rst_n            (rst_n),
		.ev               (ev_out),
		.kbd_mouse_strobe (KBD_MOUSE_STROBE),
		.kms_level        (KMS_LEVEL),
		.kbd_mouse_type   (KBD_MOUSE_TYPE),
		.kbd_mouse_data   (KBD_MOUSE_DATA)
	);

	video_meter i_meter (
		.clk_100   (clk_100),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix),
		.de        (de),
		.hs        (hs),
		.vs        (vs),
		.f1        (f1),
		.vid_nres  (vid_nres),
		.vid_hcnt  (vid_hcnt),
		.vid_vcnt  (vid_vcnt),
		.vid_htime (vid_htime),
		.vid_vtime (vid_vtime)
	);

endmodule

//--- kms_event_fifo.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module kms_event_fifo (
	input logic clk_100,
	input logic rst_n,
	kms_event_if.consumer wr,
	kms_event_if.producer rd
);
	localparam int DEPTH = `HPS_KMS_DEPTH;
	localparam int AW    = $clog2(DEPTH);
	localparam int CW    = $clog2(DEPTH + 1);

	logic [9:0]    mem [DEPTH];  // {kind, data}
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push;
	logic          pop;

	assign wr.ready = (count != CW'(DEPTH));
	assign rd.valid = (count != '0);
	assign rd.kind  = hps_io_pkg::kms_type_e'(mem[rd_ptr][9:8]);
	assign rd.data  = mem[rd_ptr][7:0];

	assign push = wr.valid && wr.ready;
	assign pop  = rd.valid && rd.ready;

	always_ff @(posedge clk_100) begin
		if (push)
			mem[wr_ptr] <= {wr.kind, wr.data};
	end

	always_ff @(posedge clk_100) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge clk_100) disable iff (!rst_n)
		count <= CW'(DEPTH));

	// equal pointers mean empty unless the count says full
	a_no_pop_empty: assert property (@(posedge clk_100) disable iff (!rst_n)
		pop |-> ((wr_ptr != rd_ptr) || (count == CW'(DEPTH))));

endmodule

//--- kms_event_if.sv
`timescale 1ns/10ps

// one keyboard/mouse event, moves when valid and ready are both high
interface kms_event_if;
	logic                  valid;
	logic                  ready;
	hps_io_pkg::kms_type_e kind;
	logic [7:0]            data;

	modport producer (
		output valid,
		output kind,
		output data,
		input  ready
	);

	modport consumer (
		input  valid,
		input  kind,
		input  data,
		output ready
	);
endinterface

//--- kms_output.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module kms_output (
	input  logic       clk_100,
	input  logic       rst_n,
	kms_event_if.consumer ev,
	output logic       kbd_mouse_strobe,
	output logic       kms_level,
	output logic [1:0] kbd_mouse_type,
	output logic [7:0] kbd_mouse_data
);
	localparam int GAP = `HPS_KMS_GAP;
	localparam int GW  = $clog2(GAP + 1);

	logic [GW-1:0] gap_cnt;
	logic          pop;

	assign ev.ready = (gap_cnt == '0);  // blocked during the gap
	assign pop      = ev.valid && ev.ready;

	always_ff @(posedge clk_100) begin
		if (!rst_n) begin
			gap_cnt          <= '0;
			kbd_mouse_strobe <= 1'b0;
			kms_level        <= 1'b0;
			kbd_mouse_type   <= '0;
			kbd_mouse_data   <= '0;
		end else begin
			kbd_mouse_strobe <= pop;
			if (pop) begin
				gap_cnt        <= GW'(GAP - 1);
				kms_level      <= ~kms_level;
				kbd_mouse_type <= ev.kind;
				kbd_mouse_data <= ev.data;
			end else if (gap_cnt != '0) begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

endmodule

//--- tb_hps_checker.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module tb_hps_checker (
	input logic        clk_100,
	input logic        rst_n,
	input logic        io_ena,
	input logic        io_strobe,
	input logic        io_wait,
	input logic [63:0] joy,          // {JOY3, JOY2, JOY1, JOY0}
	input logic [5:0]  btn_conf,     // {CONF, BUTTONS}
	input logic [2:0]  mouse_buttons,
	input logic [63:0] rtc,
	input logic [47:0] scr,          // {svbl_b, svbl_t, shbl_r, shbl_l}
	input logic        sset,
	input logic        kms_strobe,
	input logic        kms_level,
	input logic [1:0]  kms_type,
	input logic [7:0]  kms_data,
	input logic [63:0] exp_joy,
	input logic [5:0]  exp_btn_conf,
	input logic [2:0]  exp_mouse_buttons,
	input logic [63:0] exp_rtc,
	input logic [47:0] exp_scr,
	input logic        exp_sset_cmd
);
	int         err_cnt = 0;
	int         chk_cnt = 0;
	logic [9:0] exp_ev [$];  // {kind, data}
	logic [9:0] e;
	logic       ena_d;
	logic       fall_d;
	logic       last_level;
	int         since_strobe;
	int         wait_left;

	task automatic compare_value(input string name, input logic [63:0] exp,
	                             input logic [63:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s exp=%h got=%h", name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		err_cnt++;
		$display("error: %s", what);
	endtask

	task automatic expect_event(input logic [1:0] kind, input logic [7:0] data);
		exp_ev.push_back({kind, data});
	endtask

	function automatic int pending_events();
		return exp_ev.size();
	endfunction

	always @(posedge clk_100) begin
		if (!rst_n) begin
			ena_d        = 1'b0;
			fall_d       = 1'b0;
			last_level   = 1'b0;
			since_strobe = `HPS_KMS_GAP;
			wait_left    = 0;
		end else begin
			compare_value("sset", 64'(fall_d && exp_sset_cmd), 64'(sset));
			fall_d = ena_d && !io_ena;  // sset due one cycle after the fall
			ena_d  = io_ena;
			if (wait_left > 0) begin  // wait window after each word
				compare_value("IO_WAIT", 64'h1, 64'(io_wait));
				wait_left--;
			end
			if (io_ena && io_strobe)
				wait_left = `HPS_WAIT_CYCLES;
			if (!io_ena) begin  // registers settle between commands
				compare_value("JOY", exp_joy, joy);
				compare_value("BUTTONS_CONF", 64'(exp_btn_conf), 64'(btn_conf));
				compare_value("MOUSE_BUTTONS", 64'(exp_mouse_buttons), 64'(mouse_buttons));
				compare_value("RTC", exp_rtc, rtc);
				compare_value("SCREEN_SET", 64'(exp_scr), 64'(scr));
			end
			if (since_strobe < 1000)
				since_strobe++;
			if (kms_strobe) begin
				if (since_strobe < `HPS_KMS_GAP)
					report_failure("event strobes closer than the minimum gap");
				since_strobe = 0;
				compare_value("KMS_LEVEL", 64'(!last_level), 64'(kms_level));
				last_level = kms_level;
				if (exp_ev.size() == 0) begin
					report_failure("event strobe with no event expected");
				end else begin
					e = exp_ev.pop_front();
					compare_value("KBD_MOUSE_TYPE", 64'(e[9:8]), 64'(kms_type));
					compare_value("KBD_MOUSE_DATA", 64'(e[7:0]), 64'(kms_data));
				end
			end
		end
	end

endmodule

//--- tb_hps_io.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module tb_hps_io;
	localparam int N_CMDS    = 150;
	localparam int N_BURST   = 3 * (`HPS_KMS_DEPTH + 4);
	localparam int MAX_FRAME = 2 * 48 * 14;  // largest frame in clk_100 cycles
	localparam int LIMIT     = (N_CMDS + N_BURST + 4) * 60
	                           + (2 * `HPS_STABLE_FRAMES + 14) * MAX_FRAME;

	logic        clk_100;
	logic        rst_n;
	logic        io_ena;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic        io_wait;
	logic [63:0] joy;
	logic [5:0]  btn_conf;
	logic [2:0]  mouse_buttons;
	logic [63:0] rtc;
	logic [47:0] scr;
	logic        sset;
	logic        kms_strobe;
	logic        kms_level;
	logic [1:0]  kms_type;
	logic [7:0]  kms_data;
	logic        ce_pix;
	logic        de;
	logic        hs;
	logic        vs;
	logic        f1;
	logic [63:0] exp_joy = '0;
	logic [5:0]  exp_btn_conf = '0;
	logic [2:0]  exp_mouse_buttons = '0;
	logic [63:0] exp_rtc = '0;
	logic [47:0] exp_scr = '0;
	logic        exp_sset_cmd = 1'b0;
	logic [15:0] words [16];
	logic [15:0] douts [16];
	logic [7:0]  nres0;
	logic        big = 1'b0;  // second video size
	int          h_act;
	int          h_tot;
	int          v_act;
	int          v_tot;
	int          frame_cnt = 0;

	hps_io_sys i_dut (
		.clk_100 (clk_100), .rst_n (rst_n),
		.IO_ENA (io_ena), .IO_STROBE (io_strobe), .IO_DIN (io_din),
		.IO_DOUT (io_dout), .IO_WAIT (io_wait),
		.JOY0 (joy[15:0]), .JOY1 (joy[31:16]), .JOY2 (joy[47:32]), .JOY3 (joy[63:48]),
		.MOUSE_BUTTONS (mouse_buttons), .KBD_MOUSE_STROBE (kms_strobe),
		.KMS_LEVEL (kms_level), .KBD_MOUSE_TYPE (kms_type), .KBD_MOUSE_DATA (kms_data),
		.BUTTONS (btn_conf[1:0]), .CONF (btn_conf[5:2]),
		.ce_pix (ce_pix), .de (de), .hs (hs), .vs (vs), .f1 (f1),
		.shbl_l (scr[11:0]), .shbl_r (scr[23:12]), .svbl_t (scr[35:24]),
		.svbl_b (scr[47:36]), .sset (sset), .RTC (rtc)
	);

	tb_hps_checker i_chk (.*);

	initial begin
		clk_100 = 1'b0;
		forever #10 clk_100 = ~clk_100;
	end

	// video source, one pixel every other clock
	initial begin
		ce_pix = 1'b0;
		de     = 1'b0;
		hs     = 1'b0;
		vs     = 1'b0;
		f1     = 1'b0;
		forever begin
			h_act = big ? 28 : 24;
			h_tot = big ? 48 : 40;
			v_act = big ? 9 : 8;
			v_tot = big ? 14 : 12;
			for (int y = 0; y < v_tot; y++) begin
				for (int x = 0; x < h_tot; x++) begin
					@(negedge clk_100);
					ce_pix = 1'b1;
					de     = (x >= 4) && (x < 4 + h_act) && (y >= 1) && (y < 1 + v_act);
					hs     = (x >= h_tot - 8);
					vs     = (y >= v_tot - 2);
					@(negedge clk_100);
					ce_pix = 1'b0;
				end
			end
			frame_cnt++;
		end
	end

	task automatic send_cmd(input int n);
		repeat (3) @(negedge clk_100);
		exp_sset_cmd = (words[0][7:0] == 8'(hps_io_pkg::CMD_SCREEN_SET));
		io_ena = 1'b1;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_100);
			while (io_wait)
				@(negedge clk_100);
			io_strobe = 1'b1;
			io_din    = words[i];
			@(negedge clk_100);
			io_strobe = 1'b0;
			douts[i]  = io_dout;
		end
		while (io_wait)
			@(negedge clk_100);
		io_ena = 1'b0;
	endtask

	task automatic random_cmd(input int pick);
		for (int i = 1; i < 5; i++)
			words[i] = 16'($urandom);
		case (pick)
			0, 1, 2, 3: begin
				words[0] = (pick < 2) ? 16'(hps_io_pkg::CMD_JOY0) + 16'(pick)
				                      : 16'(hps_io_pkg::CMD_JOY2) + 16'(pick - 2);
				send_cmd(2);
				exp_joy[pick*16 +: 16] = words[1];
			end
			4: begin
				words[0] = 16'(hps_io_pkg::CMD_BUTTONS);
				send_cmd(2);
				exp_btn_conf = {words[1][7:4], words[1][1:0]};
			end
			5: begin
				words[0] = 16'(hps_io_pkg::CMD_SCREEN_SET);
				send_cmd(5);
				exp_scr = {words[4][11:0], words[3][11:0], words[2][11:0], words[1][11:0]};
			end
			6, 7: begin
				words[0] = 16'((pick == 6) ? hps_io_pkg::CMD_KBD : hps_io_pkg::CMD_OSD_KBD);
				i_chk.expect_event((pick == 6) ? 2'(hps_io_pkg::KMS_KEY)
				                               : 2'(hps_io_pkg::KMS_OSD_KEY), words[1][7:0]);
				send_cmd(2);
			end
			8: begin
				words[0] = 16'(hps_io_pkg::CMD_MOUSE);
				i_chk.expect_event(2'(hps_io_pkg::KMS_MOUSE_X), words[1][7:0]);
				i_chk.expect_event(2'(hps_io_pkg::KMS_MOUSE_Y), words[2][7:0]);
				send_cmd(4);
				exp_mouse_buttons = words[3][2:0];
			end
			9: begin
				words[0] = 16'(hps_io_pkg::CMD_RTC);
				send_cmd(5);
				exp_rtc = {words[4], words[3], words[2], words[1]};  // low word first
			end
			10: begin
				words[0] = 16'(hps_io_pkg::CMD_IDENT);
				send_cmd(1);
				i_chk.compare_value("IO_DOUT ident", 64'h1, 64'(douts[0]));
			end
			default: begin
				words[0] = 16'(hps_io_pkg::CMD_UART_FLAGS);
				send_cmd(1);
				i_chk.compare_value("IO_DOUT uart", 64'h1F1F, 64'(douts[0]));
			end
		endcase
	endtask

	task automatic read_video(input logic check_nres);
		words[0] = 16'(hps_io_pkg::CMD_VIDEO_INFO);
		for (int i = 1; i < 10; i++)
			words[i] = 16'h0000;
		send_cmd(10);
		if (check_nres)
			i_chk.compare_value("IO_DOUT nres", 64'(nres0 + 8'd1), 64'(douts[1]));
		nres0 = douts[1][7:0];
		i_chk.compare_value("IO_DOUT hcnt", 64'(h_act), 64'({douts[3], douts[2]}));
		i_chk.compare_value("IO_DOUT vcnt", 64'(v_act), 64'({douts[5], douts[4]}));
		i_chk.compare_value("IO_DOUT htime", 64'(2 * h_tot), 64'({douts[7], douts[6]}));
		i_chk.compare_value("IO_DOUT vtime", 64'(2 * h_tot * v_tot), 64'({douts[9], douts[8]}));
	endtask

	initial begin
		int c0;
		void'($urandom(32'hf53c4ec9));
		rst_n     = 1'b0;
		io_ena    = 1'b0;
		io_strobe = 1'b0;
		io_din    = 16'h0000;
		repeat (16) @(negedge clk_100);
		rst_n = 1'b1;
		for (int i = 0; i < N_CMDS; i++)
			random_cmd(int'($urandom % 12));
		for (int i = 0; i < N_BURST; i++)  // key, osd and mouse only
			random_cmd(6 + int'($urandom % 3));
		while (frame_cnt < `HPS_STABLE_FRAMES + 5)
			@(negedge clk_100);
		read_video(1'b0);
		big = 1'b1;
		c0  = frame_cnt;
		while (frame_cnt < c0 + `HPS_STABLE_FRAMES + 5)
			@(negedge clk_100);
		read_video(1'b1);
		while (i_chk.pending_events() != 0)
			@(negedge clk_100);
		repeat (10) @(negedge clk_100);
		$display("checks=%0d errors=%0d", i_chk.chk_cnt, i_chk.err_cnt);
		if (i_chk.err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		repeat (LIMIT) @(posedge clk_100);
		$display("timeout, run did not finish within %0d cycles", LIMIT);
		$display("checks=%0d errors=%0d", i_chk.chk_cnt, i_chk.err_cnt);
		$display("sim failed");
		$finish;
	end

endmodule

//--- video_meter.sv
`timescale 1ns/10ps
`include "hps_io_defines.svh"

module video_meter (
	input  logic        clk_100,
	input  logic        rst_n,
	input  logic        ce_pix,
	input  logic        de,
	input  logic        hs,
	input  logic        vs,
	input  logic        f1,
	output logic [7:0]  vid_nres,
	output logic [31:0] vid_hcnt,
	output logic [31:0] vid_vcnt,
	output logic [31:0] vid_htime,
	output logic [31:0] vid_vtime
);
	localparam int STABLE = `HPS_STABLE_FRAMES;
	localparam int SW     = $clog2(STABLE + 1);

	logic          old_vs;  // sampled with ce_pix
	logic          old_de;
	logic          calch;   // inside first active line
	logic [31:0]   hcnt;
	logic [31:0]   vcnt;
	logic [SW-1:0] resto;
	logic          frame_end;
	logic          hs_d;
	logic          vs_d;
	logic [31:0]   htime;
	logic [31:0]   vtime;
	logic [31:0]   line_per;
	logic [31:0]   frame_per;

	assign frame_end = ce_pix && old_vs && !vs;

	always_ff @(posedge clk_100) begin
		if (!rst_n) begin
			old_vs    <= 1'b0;
			old_de    <= 1'b0;
			calch     <= 1'b0;
			hcnt      <= '0;
			vcnt      <= '0;
			resto     <= '0;
			vid_nres  <= '0;
			vid_hcnt  <= '0;
			vid_vcnt  <= '0;
			vid_htime <= '0;
			vid_vtime <= '0;
		end else if (ce_pix) begin
			old_vs <= vs;
			old_de <= de;
			if (!old_de && de)
				vcnt <= vcnt + 32'd1;
			if (calch && de)
				hcnt <= hcnt + 32'd1;
			if (old_de && !de)
				calch <= 1'b0;

			if (frame_end) begin
				if (!f1 && hcnt != '0 && vcnt != '0) begin
					if (hcnt != vid_hcnt || vcnt != vid_vcnt) begin
						resto <= SW'(1);  // size changed, restart
					end else if (resto == SW'(STABLE)) begin
						vid_nres <= vid_nres + 8'd1;
						resto    <= '0;
					end else if (resto != '0) begin
						resto <= resto + 1'b1;
					end
					vid_hcnt  <= hcnt;
					vid_vcnt  <= vcnt;
					vid_htime <= line_per;
					vid_vtime <= frame_per;
				end
				hcnt  <= '0;
				vcnt  <= '0;
				calch <= 1'b1;
			end
		end
	end

	// periods in clk_100 cycles, rise to rise
	always_ff @(posedge clk_100) begin
		if (!rst_n) begin
			hs_d      <= 1'b0;
			vs_d      <= 1'b0;
			htime     <= '0;
			vtime     <= '0;
			line_per  <= '0;
			frame_per <= '0;
		end else begin
			hs_d  <= hs;
			vs_d  <= vs;
			htime <= htime + 32'd1;
			vtime <= vtime + 32'd1;
			if (hs && !hs_d) begin
				line_per <= htime;
				htime    <= 32'd1;
			end
			if (vs && !vs_d) begin
				frame_per <= vtime;
				vtime     <= 32'd1;
			end
		end
	end

endmodule
